// File: alu.sv
`timescale 1ns/1ps

module alu import tomasulo_pkg::*; (
    input  res_word   alu_word_i,
    output rv32i_word result_o
);

    rv32i_word  a;
    rv32i_word  b;
    logic [4:0] shamt;

    assign a     = alu_word_i.src1.data;
    assign b     = alu_word_i.src2.data;
    assign shamt = b[4:0];

    always_comb begin
        case (alu_word_i.operation.funct3)
            3'b000: begin
                // lui rides on the add slot and passes the immediate
                if (alu_word_i.operation.is_lui) begin
                    result_o = b;
                end else if (alu_word_i.operation.funct7_b5) begin
                    result_o = a - b;
                end else begin
                    result_o = a + b;
                end
            end
            3'b001:  result_o = a << shamt;
            3'b010:  result_o = {31'd0, $signed(a) < $signed(b)};
            3'b011:  result_o = {31'd0, a < b};
            3'b100:  result_o = a ^ b;
            3'b101:  result_o = alu_word_i.operation.funct7_b5 ? rv32i_word'($signed(a) >>> shamt)
                                                               : a >> shamt;
            3'b110:  result_o = a | b;
            default: result_o = a & b;
        endcase
    end

endmodule

// File: cdb.sv
`timescale 1ns/1ps

module cdb import tomasulo_pkg::*; (
    input logic      clk,
    input logic      arst_n_i,
    cdb_itf.alu_side bus
);

    logic [ROB_DEPTH-1:0]      done_q;
    rv32i_word [ROB_DEPTH-1:0] slot_q;

    // one slot per rob tag, so no arbitration between alus
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            done_q <= '0;
        end else begin
            if (bus.clear) begin
                done_q[bus.clear_tag] <= 1'b0;
            end
            for (int k = 0; k < NUM_RS; k++) begin
                if (bus.exec[k]) begin
                    done_q[bus.tag[k]] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int k = 0; k < NUM_RS; k++) begin
            if (bus.exec[k]) begin
                slot_q[bus.tag[k]] <= bus.result[k];
            end
        end
    end

    assign bus.done      = done_q;
    assign bus.slot_data = slot_q;

endmodule

// File: ir.sv
`timescale 1ns/1ps

module ir import tomasulo_pkg::*; (
    input  logic      clk,
    input  logic      arst_n_i,
    input  logic      instr_mem_resp_i,
    input  rv32i_word instr_mem_rdata_i,
    output logic      instr_read_o,
    output rv32i_word instr_mem_address_o,
    issue_itf.fetch   iss
);

    rv32i_word   pc_q;
    instr_u      ir_q;
    logic        full_q;
    logic        read_q;
    rv32i_opcode opc;
    res_op_t     op;
    rv32i_word   imm;
    logic        imm_valid;
    logic        issue;

    assign opc = rv32i_opcode'(ir_q.r_fmt.opcode);

    ////////////////////////////////////////////////////////////////////////////
    // decode
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        op        = '0;
        imm       = '0;
        imm_valid = 1'b1;
        iss.rd    = '0;
        iss.rs1   = '0;
        iss.rs2   = '0;
        case (opc)
            op_imm: begin
                iss.rd    = ir_q.i_fmt.rd;
                iss.rs1   = ir_q.i_fmt.rs1;
                op.funct3 = ir_q.i_fmt.funct3;
                imm       = {{20{ir_q.i_fmt.imm12[11]}}, ir_q.i_fmt.imm12};
                // shifts take shamt only, bit 30 picks srai
                if (ir_q.i_fmt.funct3 == 3'b001 || ir_q.i_fmt.funct3 == 3'b101) begin
                    imm          = {27'd0, ir_q.i_fmt.imm12[4:0]};
                    op.funct7_b5 = ir_q.r_fmt.funct7[5];
                end
            end
            op_reg: begin
                iss.rd       = ir_q.r_fmt.rd;
                iss.rs1      = ir_q.r_fmt.rs1;
                iss.rs2      = ir_q.r_fmt.rs2;
                op.funct3    = ir_q.r_fmt.funct3;
                op.funct7_b5 = ir_q.r_fmt.funct7[5];
                imm_valid    = 1'b0;
            end
            op_lui: begin
                iss.rd    = ir_q.r_fmt.rd;
                op.is_lui = 1'b1;
                imm       = {ir_q[31:12], 12'd0};
            end
            // anything else becomes x0 = 0 + 0
            default: ;
        endcase
    end

    // immediate replaces the second register operand
    always_comb begin
        iss.word.operation = op;
        iss.word.src1      = iss.src1;
        iss.word.src2      = iss.src2;
        if (imm_valid) begin
            iss.word.src2.tag   = '0;
            iss.word.src2.data  = imm;
            iss.word.src2.valid = 1'b1;
        end
        iss.word.rd_tag = iss.curr_tag;
    end

    // lowest numbered empty station wins
    always_comb begin : pick_station
        logic found;
        found       = 1'b0;
        issue       = full_q && !iss.rob_full && (|iss.rs_empty);
        iss.rs_load = '0;
        for (int k = 0; k < NUM_RS; k++) begin
            if (iss.rs_empty[k] && !found) begin
                iss.rs_load[k] = issue;
                found          = 1'b1;
            end
        end
    end

    assign iss.rob_load = issue;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q   <= '0;
            full_q <= 1'b0;
            read_q <= 1'b0;
        end else if (read_q && instr_mem_resp_i) begin
            read_q <= 1'b0;
            full_q <= 1'b1;
        end else if (issue) begin
            full_q <= 1'b0;
            read_q <= 1'b1;
            pc_q   <= pc_q + 32'd4;
        end else if (!read_q && !full_q) begin
            // first request out of reset
            read_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (read_q && instr_mem_resp_i) begin
            ir_q <= instr_mem_rdata_i;
        end
    end

    assign instr_read_o        = read_q;
    assign instr_mem_address_o = pc_q;

endmodule

// File: mp4.sv
`timescale 1ns/1ps

module mp4 import tomasulo_pkg::*; (
    input  logic       clk,
    input  logic       arst_n_i,
    input  logic       instr_mem_resp_i,
    input  rv32i_word  instr_mem_rdata_i,
    output logic       instr_read_o,
    output rv32i_word  instr_mem_address_o,
    output logic       commit_valid_o,
    output logic [4:0] commit_rd_o,
    output rv32i_word  commit_data_o
);

    issue_itf iss();
    cdb_itf   bus();

    // commit write port into the register file
    logic             wr_en;
    logic [4:0]       wr_rd;
    logic [TAG_W-1:0] wr_tag;
    rv32i_word        wr_data;

    ////////////////////////////////////////////////////////////////////////////
    // front end and in-order state
    ////////////////////////////////////////////////////////////////////////////

    ir ir_i (
        .clk                 (clk),
        .arst_n_i            (arst_n_i),
        .instr_mem_resp_i    (instr_mem_resp_i),
        .instr_mem_rdata_i   (instr_mem_rdata_i),
        .instr_read_o        (instr_read_o),
        .instr_mem_address_o (instr_mem_address_o),
        .iss                 (iss.fetch)
    );

    rob rob_i (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .iss            (iss.rob),
        .bus            (bus.rob),
        .commit_valid_o (commit_valid_o),
        .commit_rd_o    (commit_rd_o),
        .commit_data_o  (commit_data_o),
        .wr_en_o        (wr_en),
        .wr_rd_o        (wr_rd),
        .wr_tag_o       (wr_tag),
        .wr_data_o      (wr_data)
    );

    regfile regfile_i (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .iss       (iss.regfile),
        .wr_en_i   (wr_en),
        .wr_rd_i   (wr_rd),
        .wr_tag_i  (wr_tag),
        .wr_data_i (wr_data)
    );

    cdb cdb_i (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .bus      (bus.alu_side)
    );

    ////////////////////////////////////////////////////////////////////////////
    // execution lanes, one station per alu
    ////////////////////////////////////////////////////////////////////////////

    for (genvar k = 0; k < NUM_RS; k++) begin : g_lane
        res_word alu_word;

        reservation_station rs_i (
            .clk        (clk),
            .arst_n_i   (arst_n_i),
            .load_i     (iss.rs_load[k]),
            .iss        (iss.station),
            .bus        (bus.station),
            .empty_o    (iss.rs_empty[k]),
            .exec_o     (bus.exec[k]),
            .alu_word_o (alu_word)
        );

        alu alu_i (
            .alu_word_i (alu_word),
            .result_o   (bus.result[k])
        );

        assign bus.tag[k] = alu_word.rd_tag;
    end

endmodule

// File: regfile.sv
`timescale 1ns/1ps

module regfile import tomasulo_pkg::*; (
    input  logic             clk,
    input  logic             arst_n_i,
    issue_itf.regfile        iss,
    input  logic             wr_en_i,
    input  logic [4:0]       wr_rd_i,
    input  logic [TAG_W-1:0] wr_tag_i,
    input  rv32i_word        wr_data_i
);

    rv32i_word        data_q  [32];
    logic             valid_q [32];
    logic [TAG_W-1:0] tag_q   [32];

    // read with bypass of a matching commit in this cycle
    function automatic res_src_t read_src(input logic [4:0] idx);
        res_src_t src;
        src.tag   = tag_q[idx];
        src.data  = data_q[idx];
        src.valid = valid_q[idx];
        if (idx == 5'd0) begin
            src.tag   = '0;
            src.data  = '0;
            src.valid = 1'b1;
        end else if (wr_en_i && wr_rd_i == idx && !valid_q[idx] && tag_q[idx] == wr_tag_i) begin
            src.data  = wr_data_i;
            src.valid = 1'b1;
        end
        return src;
    endfunction

    always_comb begin
        iss.src1 = read_src(iss.rs1);
        iss.src2 = read_src(iss.rs2);
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                data_q[i]  <= '0;
                valid_q[i] <= 1'b1;
                tag_q[i]   <= '0;
            end
        end else begin
            if (wr_en_i && wr_rd_i != 5'd0) begin
                data_q[wr_rd_i] <= wr_data_i;
                // a newer rename keeps the register pending
                if (tag_q[wr_rd_i] == wr_tag_i) begin
                    valid_q[wr_rd_i] <= 1'b1;
                end
            end
            // rename last so it beats a same-cycle commit
            if (iss.rob_load && iss.rd != 5'd0) begin
                valid_q[iss.rd] <= 1'b0;
                tag_q[iss.rd]   <= iss.curr_tag;
            end
        end
    end

endmodule

// File: reservation_station.sv
`timescale 1ns/1ps

module reservation_station import tomasulo_pkg::*; (
    input  logic       clk,
    input  logic       arst_n_i,
    input  logic       load_i,
    issue_itf.station  iss,
    cdb_itf.station    bus,
    output logic       empty_o,
    output logic       exec_o,
    output res_word    alu_word_o
);

    logic    busy_q;
    res_word word_q;
    res_word base;
    res_word word_d;

    // pick up a waiting operand once its tag is done
    function automatic res_src_t capture(
        input res_src_t                  src,
        input logic [ROB_DEPTH-1:0]      done,
        input rv32i_word [ROB_DEPTH-1:0] slots
    );
        res_src_t upd;
        upd = src;
        if (!src.valid && done[src.tag]) begin
            upd.data  = slots[src.tag];
            upd.valid = 1'b1;
        end
        return upd;
    endfunction

    always_comb begin
        base        = load_i ? iss.word : word_q;
        word_d      = base;
        word_d.src1 = capture(base.src1, bus.done, bus.slot_data);
        word_d.src2 = capture(base.src2, bus.done, bus.slot_data);
    end

    // fire as soon as both operands are present
    assign exec_o     = busy_q && word_q.src1.valid && word_q.src2.valid;
    assign empty_o    = !busy_q;
    assign alu_word_o = word_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q <= 1'b0;
        end else if (load_i) begin
            busy_q <= 1'b1;
        end else if (exec_o) begin
            busy_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load_i || busy_q) begin
            word_q <= word_d;
        end
    end

endmodule

// File: rob.sv
`timescale 1ns/1ps

module rob import tomasulo_pkg::*; (
    input  logic             clk,
    input  logic             arst_n_i,
    issue_itf.rob            iss,
    cdb_itf.rob              bus,
    output logic             commit_valid_o,
    output logic [4:0]       commit_rd_o,
    output rv32i_word        commit_data_o,
    output logic             wr_en_o,
    output logic [4:0]       wr_rd_o,
    output logic [TAG_W-1:0] wr_tag_o,
    output rv32i_word        wr_data_o
);

    logic [TAG_W-1:0]     head_q;
    logic [TAG_W-1:0]     tail_q;
    logic [TAG_W:0]       count_q;
    logic [ROB_DEPTH-1:0] busy_q;
    logic [4:0]           rd_q [ROB_DEPTH];
    logic                 commit;

    // retire strictly from the head
    assign commit = busy_q[head_q] && bus.done[head_q];

    // tail is the tag handed to the next issue
    assign iss.curr_tag = tail_q;
    assign iss.rob_full = (count_q == (TAG_W+1)'(ROB_DEPTH));

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            busy_q  <= '0;
        end else begin
            if (iss.rob_load) begin
                busy_q[tail_q] <= 1'b1;
                tail_q         <= tail_q + 1'b1;
            end
            if (commit) begin
                busy_q[head_q] <= 1'b0;
                head_q         <= head_q + 1'b1;
            end
            case ({iss.rob_load, commit})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (iss.rob_load) begin
            rd_q[tail_q] <= iss.rd;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // commit outputs
    ////////////////////////////////////////////////////////////////////////////

    assign commit_valid_o = commit;
    assign commit_rd_o    = rd_q[head_q];
    assign commit_data_o  = bus.slot_data[head_q];

    assign wr_en_o   = commit;
    assign wr_rd_o   = rd_q[head_q];
    assign wr_tag_o  = head_q;
    assign wr_data_o = bus.slot_data[head_q];

    // free the cdb slot so the tag can be reused
    assign bus.clear     = commit;
    assign bus.clear_tag = head_q;

endmodule

// File: run.sh
#!/usr/bin/env bash
# compile the core and testbench with verilator, run, then check the log

rm -rf obj_dir sim.log

verilator --binary --timing --assert -f src.f --top-module tb_mp4 -o tb_mp4_sim \
    && ./obj_dir/tb_mp4_sim | tee sim.log

grep -q "Test completed successfully" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: src.f
tomasulo_pkg.sv
tomasulo_itf.sv
alu.sv
cdb.sv
regfile.sv
reservation_station.sv
rob.sv
ir.sv
mp4.sv
tb_mp4.sv

// File: tb_mp4.sv
`timescale 1ns/1ps

module tb_mp4;

    localparam int CLK_PERIOD       = 20;
    localparam int NUM_INSTR        = 40;
    localparam int CYCLES_PER_INSTR = 30;
    localparam int WATCHDOG_CYCLES  = NUM_INSTR * CYCLES_PER_INSTR;
    localparam int DRAIN_CYCLES     = 20;

    logic        clk = 1'b0;
    logic        arst_n;
    logic        instr_mem_resp;
    logic [31:0] instr_mem_rdata;
    logic        instr_read;
    logic [31:0] instr_mem_address;
    logic        commit_valid;
    logic [4:0]  commit_rd;
    logic [31:0] commit_data;

    // program image and expected commit stream
    logic [31:0] prog     [NUM_INSTR];
    logic [4:0]  exp_rd   [NUM_INSTR];
    logic [31:0] exp_data [NUM_INSTR];
    logic [31:0] ref_regs [8];
    int          n_commits = 0;

    // instruction memory state
    logic        waiting   = 1'b0;
    logic [31:0] next_addr = '0;
    logic [31:0] cur_addr;
    int          delay;

    mp4 mp4_i (
        .clk                 (clk),
        .arst_n_i            (arst_n),
        .instr_mem_resp_i    (instr_mem_resp),
        .instr_mem_rdata_i   (instr_mem_rdata),
        .instr_read_o        (instr_read),
        .instr_mem_address_o (instr_mem_address),
        .commit_valid_o      (commit_valid),
        .commit_rd_o         (commit_rd),
        .commit_data_o       (commit_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] expected, input int idx);
        abort_run($sformatf("MISMATCH %s: got %h expected %h (instruction %0d)",
                            name, got, expected, idx));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // program generation and reference model
    ////////////////////////////////////////////////////////////////////////////

    // one supported instruction with registers limited to x0..x7
    function automatic logic [31:0] random_instr();
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        int          kind;
        r    = $urandom;
        rd   = {2'b00, r[2:0]};
        rs1  = {2'b00, r[5:3]};
        rs2  = {2'b00, r[8:6]};
        kind = int'($urandom % 20);
        f7   = (kind == 1 || kind == 7 || kind == 18) ? 7'h20 : 7'h00;
        case (kind)
            0, 1, 10: f3 = 3'd0;
            2, 16:    f3 = 3'd1;
            3, 11:    f3 = 3'd2;
            4, 12:    f3 = 3'd3;
            5, 13:    f3 = 3'd4;
            6, 7:     f3 = 3'd5;
            17, 18:   f3 = 3'd5;
            8, 14:    f3 = 3'd6;
            default:  f3 = 3'd7;
        endcase
        if (kind < 10) begin
            return {f7, rs2, rs1, f3, rd, 7'b0110011};
        end else if (kind >= 16 && kind <= 18) begin
            // shift immediates carry shamt and the arithmetic bit
            return {f7, r[24:20], rs1, f3, rd, 7'b0010011};
        end else if (kind < 19) begin
            return {r[31:20], rs1, f3, rd, 7'b0010011};
        end
        return {r[31:12], rd, 7'b0110111};
    endfunction

    // rv32i semantics straight from the instruction word
    function automatic logic [31:0] ref_result(input logic [31:0] w,
                                               input logic [31:0] a,
                                               input logic [31:0] rv2);
        logic [31:0] b;
        logic [31:0] res;
        if (w[6:0] == 7'b0110111) begin
            return {w[31:12], 12'd0};
        end
        b = (w[6:0] == 7'b0010011) ? {{20{w[31]}}, w[31:20]} : rv2;
        case (w[14:12])
            3'd0:    res = (w[6:0] == 7'b0110011 && w[30]) ? a - b : a + b;
            3'd1:    res = a << b[4:0];
            3'd2:    res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    res = (a < b) ? 32'd1 : 32'd0;
            3'd4:    res = a ^ b;
            3'd5: begin
                if (w[30]) begin
                    res = $signed(a) >>> b[4:0];
                end else begin
                    res = a >> b[4:0];
                end
            end
            3'd6:    res = a | b;
            default: res = a & b;
        endcase
        return res;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // instruction memory with random 0..3 cycle latency
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (arst_n) begin
            if (instr_mem_resp) begin
                instr_mem_resp = 1'b0;
                waiting        = 1'b0;
            end else if (instr_read) begin
                if (!waiting) begin
                    assert (instr_mem_address == next_addr) else
                        report_mismatch("instr_mem_address_o", instr_mem_address,
                                        next_addr, int'(next_addr >> 2));
                    cur_addr  = instr_mem_address;
                    next_addr = next_addr + 32'd4;
                    delay     = int'($urandom % 4);
                    waiting   = 1'b1;
                end
                assert (instr_mem_address == cur_addr) else
                    report_mismatch("instr_mem_address_o", instr_mem_address,
                                    cur_addr, int'(cur_addr >> 2));
                // past the program the memory stays silent
                if (delay == 0 && cur_addr < NUM_INSTR * 4) begin
                    instr_mem_resp  = 1'b1;
                    instr_mem_rdata = prog[cur_addr[7:2]];
                end else if (delay != 0) begin
                    delay = delay - 1;
                end
            end else begin
                assert (!waiting) else
                    abort_run("instr_read_o dropped before the memory response");
            end
        end
    end

    // commit stream against the reference
    always @(negedge clk) begin
        if (arst_n && commit_valid) begin
            assert (n_commits < NUM_INSTR) else
                abort_run("commit seen after the last program instruction");
            assert (commit_rd == exp_rd[n_commits]) else
                report_mismatch("commit_rd_o", {27'd0, commit_rd},
                                {27'd0, exp_rd[n_commits]}, n_commits);
            if (exp_rd[n_commits] != 5'd0) begin
                assert (commit_data == exp_data[n_commits]) else
                    report_mismatch("commit_data_o", commit_data,
                                    exp_data[n_commits], n_commits);
            end
            n_commits = n_commits + 1;
        end
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        abort_run($sformatf("timeout after %0d cycles with %0d of %0d commits",
                            WATCHDOG_CYCLES, n_commits, NUM_INSTR));
    end

    initial begin : main
        arst_n          = 1'b0;
        instr_mem_resp  = 1'b0;
        instr_mem_rdata = '0;
        void'($urandom(32'h8d4e));

        for (int i = 0; i < 8; i++) begin
            ref_regs[i] = '0;
        end
        for (int i = 0; i < NUM_INSTR; i++) begin
            prog[i]     = random_instr();
            exp_rd[i]   = prog[i][11:7];
            exp_data[i] = ref_result(prog[i], ref_regs[prog[i][17:15]],
                                     ref_regs[prog[i][22:20]]);
            if (exp_rd[i] != 5'd0) begin
                ref_regs[exp_rd[i][2:0]] = exp_data[i];
            end
        end

        repeat (3) begin
            @(negedge clk);
            assert (!instr_read && !commit_valid) else
                abort_run("instr_read_o or commit_valid_o high during reset");
        end
        arst_n = 1'b1;

        wait (n_commits == NUM_INSTR);
        // any extra commit in this window trips the commit checker
        repeat (DRAIN_CYCLES) @(negedge clk);

        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: tomasulo_itf.sv
`timescale 1ns/1ps

// issue path from fetch into rob, register file and stations
interface issue_itf import tomasulo_pkg::*; ();
    logic              rob_load;
    logic [NUM_RS-1:0] rs_load;
    logic [4:0]        rd;
    logic [4:0]        rs1;
    logic [4:0]        rs2;
    res_word           word;
    logic              rob_full;
    logic [TAG_W-1:0]  curr_tag;
    res_src_t          src1;
    res_src_t          src2;
    logic [NUM_RS-1:0] rs_empty;

    modport fetch   (output rob_load, rs_load, rd, rs1, rs2, word,
                     input  rob_full, curr_tag, src1, src2, rs_empty);
    modport rob     (input  rob_load, rd, output rob_full, curr_tag);
    modport regfile (input  rob_load, rd, rs1, rs2, curr_tag, output src1, src2);
    modport station (input  word);
endinterface

// results by tag, watched by everyone waiting on an operand
interface cdb_itf import tomasulo_pkg::*; ();
    logic [NUM_RS-1:0]             exec;
    logic [NUM_RS-1:0][TAG_W-1:0]  tag;
    rv32i_word [NUM_RS-1:0]        result;
    logic [ROB_DEPTH-1:0]          done;
    rv32i_word [ROB_DEPTH-1:0]     slot_data;
    logic                          clear;
    logic [TAG_W-1:0]              clear_tag;

    modport station  (input  done, slot_data);
    modport alu_side (input  exec, tag, result, clear, clear_tag, output done, slot_data);
    modport rob      (input  done, slot_data, output clear, clear_tag);
    modport regfile  (input  done, slot_data);
endinterface

// File: tomasulo_pkg.sv
package tomasulo_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // core sizing
    ////////////////////////////////////////////////////////////////////////////

    localparam int ROB_DEPTH = 8;
    localparam int TAG_W     = 3;
    localparam int NUM_RS    = 2;

    typedef logic [31:0] rv32i_word;

    // only the major opcodes this core executes
    typedef enum logic [6:0] {
        op_imm = 7'b0010011,
        op_reg = 7'b0110011,
        op_lui = 7'b0110111
    } rv32i_opcode;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // same fetched word, register or immediate layout
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } instr_u;

    ////////////////////////////////////////////////////////////////////////////
    // reservation station word
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [2:0] funct3;
        logic       funct7_b5;
        logic       is_lui;
    } res_op_t;

    // operand either ready or waiting on a rob tag
    typedef struct packed {
        logic [TAG_W-1:0] tag;
        rv32i_word        data;
        logic             valid;
    } res_src_t;

    typedef struct packed {
        res_op_t          operation;
        res_src_t         src1;
        res_src_t         src2;
        logic [TAG_W-1:0] rd_tag;
    } res_word;

endpackage
